/* Makefile */
# verilator build and run of the object table dma testbench

BIN  := obj_dir/Vtb_obj_table
SRCS := $(shell cat obj_dma.f)

all: run

# rebuilt only when a source or the file list changes
$(BIN): obj_dma.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_obj_table -f obj_dma.f

# the log decides pass or fail
run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* obj_dma.f */
rtl/obj_pkg.sv
rtl/obj_regs.sv
rtl/obj_dma.sv
rtl/obj_table_buf.sv
rtl/obj_table_top.sv
tb/vram_model.sv
tb/tb_obj_table.sv

/* rtl/obj_dma.sv */
/*
 * object table dma sequencer
 * on vblank takes the video bus, copies the table in 3,2,1,0 entry order,
 * stops on the end code and zero-fills the rest of the write bank
 */
`timescale 1ns/1ps

module obj_dma (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               enable,
    input  logic                               vblank,
    input  logic [15:0]                        table_base,
    // bus sharing
    output logic                               busreq,
    input  logic                               busack,
    // video ram read
    output logic                               vram_cs,
    output logic [obj_pkg::VADDR_W-1:0]        vram_addr,
    input  logic [15:0]                        vram_data,
    input  logic                               vram_ok,
    // table write
    output logic                               wr_en,
    output logic [obj_pkg::TABLE_AW-1:0]       wr_addr,
    output logic [15:0]                        wr_data,
    output logic                               wr_bank,
    // status
    output logic                               busy,
    output logic                               bank,
    output logic [obj_pkg::TABLE_AW:0]         word_count
);

    logic [1:0]                   st;
    logic [obj_pkg::VADDR_W-1:0]  vram_cnt;
    logic [obj_pkg::TABLE_AW:0]   wcnt;
    logic                         wait_cycle;
    logic                         vblank_q;
    logic                         start;
    logic                         take;
    logic                         is_end;
    logic                         store;
    logic                         fill_wr;
    obj_pkg::obj_attr_t           attr;

    assign attr.raw = vram_data;
    // counters run 0,1,2,3 but the low address bits are inverted
    assign vram_addr = {vram_cnt[obj_pkg::VADDR_W-1:obj_pkg::ENTRY_AW],
                        ~vram_cnt[obj_pkg::ENTRY_AW-1:0]};
    assign wr_bank = ~bank;
    assign busy    = (st != obj_pkg::ST_IDLE);

    // only a fresh vblank edge in idle starts a copy
    assign start = vblank && !vblank_q && enable && (st == obj_pkg::ST_IDLE);
    // skip the cycle right after a word so an old ok is not taken twice
    assign take  = (st == obj_pkg::ST_COPY) && vram_ok && !wait_cycle;
    // end code only counts in the attribute word, first of each entry
    assign is_end = take && (wcnt[obj_pkg::ENTRY_AW-1:0] == '0)
                    && (attr.fields.code == obj_pkg::END_CODE);
    assign store   = take && !is_end;
    assign fill_wr = (st == obj_pkg::ST_FILL) && !wcnt[obj_pkg::TABLE_AW];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) vblank_q <= 1'b0;
        else     vblank_q <= vblank;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // reset clears bank 1 while bank 0 is shown
            st         <= obj_pkg::ST_FILL;
            wcnt       <= '0;
            vram_cnt   <= '0;
            bank       <= 1'b0;
            busreq     <= 1'b0;
            vram_cs    <= 1'b0;
            wr_en      <= 1'b0;
            wait_cycle <= 1'b0;
            word_count <= '0;
        end else begin
            wr_en <= store || fill_wr;
            case (st)
                obj_pkg::ST_IDLE: begin
                    if (start) begin
                        busreq   <= 1'b1;
                        bank     <= ~bank;
                        vram_cnt <= {table_base[9:1], 8'd0};
                        wcnt     <= '0;
                        st       <= obj_pkg::ST_GRANT;
                    end
                end
                obj_pkg::ST_GRANT: begin
                    // no read until the arbiter hands over the bus
                    if (busack) begin
                        vram_cs    <= 1'b1;
                        wait_cycle <= 1'b0;
                        st         <= obj_pkg::ST_COPY;
                    end
                end
                obj_pkg::ST_COPY: begin
                    wait_cycle <= 1'b0;
                    if (is_end) begin
                        busreq     <= 1'b0;
                        vram_cs    <= 1'b0;
                        word_count <= wcnt;
                        st         <= obj_pkg::ST_FILL;
                    end else if (store) begin
                        vram_cnt   <= vram_cnt + 1'b1;
                        wcnt       <= wcnt + 1'b1;
                        wait_cycle <= 1'b1;
                        // whole table read, nothing left to fill
                        if (wcnt == (obj_pkg::TABLE_AW + 1)'(obj_pkg::TABLE_WORDS - 1)) begin
                            busreq     <= 1'b0;
                            vram_cs    <= 1'b0;
                            word_count <= wcnt + 1'b1;
                            st         <= obj_pkg::ST_FILL;
                        end
                    end
                end
                default: begin
                    // fill until the counter passes the last word
                    if (fill_wr) wcnt <= wcnt + 1'b1;
                    else         st   <= obj_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // write payload, copied word or zero
    always_ff @(posedge clk) begin
        if (store || fill_wr) begin
            wr_addr <= {wcnt[obj_pkg::TABLE_AW-1:obj_pkg::ENTRY_AW],
                        ~wcnt[obj_pkg::ENTRY_AW-1:0]};
            wr_data <= store ? vram_data : 16'h0000;
        end
    end

    // bus is not released with a read still in flight
    a_busreq_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(busreq) |-> !$past(vram_cs && !vram_ok));
    // idle means the table is left alone
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (st == obj_pkg::ST_IDLE) |-> !wr_en);

endmodule

/* rtl/obj_pkg.sv */
/*
 * object table dma shared definitions
 * table geometry, register map, sequencer states and attribute word layout
 */
package obj_pkg;

    // one bank of the object table, in 16-bit words
    localparam int TABLE_WORDS = 1024;
    localparam int TABLE_AW    = $clog2(TABLE_WORDS);
    // words per object entry, word 3 is the attribute word
    localparam int ENTRY_WORDS = 4;
    localparam int ENTRY_AW    = $clog2(ENTRY_WORDS);
    // video ram word address width
    localparam int VADDR_W = 17;
    // attribute code that closes the table
    localparam logic [7:0] END_CODE = 8'hFF;

    // axi-lite register map, byte offsets
    localparam int REG_AW = 4;
    localparam logic [REG_AW-1:0] REG_CTRL   = 4'h0;
    localparam logic [REG_AW-1:0] REG_BASE   = 4'h4;
    localparam logic [REG_AW-1:0] REG_STATUS = 4'h8;

    // dma sequencer states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_GRANT = 2'd1;
    localparam logic [1:0] ST_COPY  = 2'd2;
    localparam logic [1:0] ST_FILL  = 2'd3;

    // attribute word, seen as a raw word or as code over low byte
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [7:0] code;
            logic [7:0] low;
        } fields;
    } obj_attr_t;

endpackage

/* rtl/obj_regs.sv */
/*
 * object dma control registers
 * axi4-lite slave with enable and table base, status read from the dma
 */
`timescale 1ns/1ps

module obj_regs (
    input  logic                       clk,
    input  logic                       rst,
    // axi4-lite write channels
    input  logic [obj_pkg::REG_AW-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    // axi4-lite read channels
    input  logic [obj_pkg::REG_AW-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    // to and from the dma
    output logic                       enable,
    output logic [15:0]                table_base,
    input  logic                       busy,
    input  logic                       bank,
    input  logic [10:0]                word_count
);

    logic pend;
    logic wr_go;
    logic rd_go;

    // one transaction at a time, writes win over reads
    assign pend    = bvalid || rvalid;
    assign wr_go   = awvalid && wvalid && !pend;
    assign rd_go   = arvalid && !pend && !wr_go;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;
    // always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            enable     <= 1'b0;
            table_base <= 16'h0000;
        end else begin
            // response held until taken
            if (bvalid && bready) bvalid <= 1'b0;
            if (rvalid && rready) rvalid <= 1'b0;
            if (wr_go) begin
                bvalid <= 1'b1;
                if (awaddr == obj_pkg::REG_CTRL && wstrb[0]) enable <= wdata[0];
                if (awaddr == obj_pkg::REG_BASE) begin
                    if (wstrb[0]) table_base[7:0]  <= wdata[7:0];
                    if (wstrb[1]) table_base[15:8] <= wdata[15:8];
                end
            end
            if (rd_go) rvalid <= 1'b1;
        end
    end

    // read data captured at acceptance, status sampled live
    always_ff @(posedge clk) begin
        if (rd_go) begin
            case (araddr)
                obj_pkg::REG_CTRL:   rdata <= {31'd0, enable};
                obj_pkg::REG_BASE:   rdata <= {16'd0, table_base};
                obj_pkg::REG_STATUS: rdata <= {5'd0, word_count, 14'd0, bank, busy};
                default:             rdata <= 32'd0;
            endcase
        end
    end

    // a response only follows an accepted request
    a_bvalid_src: assert property (@(posedge clk) disable iff (rst)
        $rose(bvalid) |-> $past(wr_go));
    a_rvalid_src: assert property (@(posedge clk) disable iff (rst)
        $rose(rvalid) |-> $past(rd_go));

endmodule

/* rtl/obj_table_buf.sv */
/*
 * double-buffered object table
 * dma writes one bank while the renderer reads the other, one cycle latency
 */
`timescale 1ns/1ps

module obj_table_buf (
    input  logic                         clk,
    // dma write port
    input  logic                         wr_en,
    input  logic                         wr_bank,
    input  logic [obj_pkg::TABLE_AW-1:0] wr_addr,
    input  logic [15:0]                  wr_data,
    // renderer read port
    input  logic                         bank,
    input  logic [obj_pkg::TABLE_AW-1:0] table_addr,
    output logic [15:0]                  table_data
);

    // both banks in one array, bank is the top address bit
    logic [15:0] mem [0:2*obj_pkg::TABLE_WORDS-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_bank, wr_addr}] <= wr_data;
        end
    end

    // registered read of the display bank
    always_ff @(posedge clk) begin
        table_data <= mem[{bank, table_addr}];
    end

    // the dma must never write the bank on display
    a_bank_split: assert property (@(posedge clk)
        wr_en |-> (wr_bank != bank));

endmodule

/* rtl/obj_table_top.sv */
/*
 * object table dma top level
 * register slave, dma sequencer and double-buffered table
 */
`timescale 1ns/1ps

module obj_table_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         vblank,
    // axi4-lite slave
    input  logic [obj_pkg::REG_AW-1:0]   awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [31:0]                  wdata,
    input  logic [3:0]                   wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [obj_pkg::REG_AW-1:0]   araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [31:0]                  rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    // video bus
    output logic                         busreq,
    input  logic                         busack,
    output logic                         vram_cs,
    output logic [obj_pkg::VADDR_W-1:0]  vram_addr,
    input  logic [15:0]                  vram_data,
    input  logic                         vram_ok,
    // renderer
    input  logic [obj_pkg::TABLE_AW-1:0] table_addr,
    output logic [15:0]                  table_data
);

    logic                         enable;
    logic [15:0]                  table_base;
    logic                         busy;
    logic                         bank;
    logic [obj_pkg::TABLE_AW:0]   word_count;
    logic                         wr_en;
    logic                         wr_bank;
    logic [obj_pkg::TABLE_AW-1:0] wr_addr;
    logic [15:0]                  wr_data;

    obj_regs u_regs (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .enable, .table_base, .busy, .bank, .word_count
    );

    obj_dma u_dma (
        .clk, .rst, .enable, .vblank, .table_base,
        .busreq, .busack,
        .vram_cs, .vram_addr, .vram_data, .vram_ok,
        .wr_en, .wr_addr, .wr_data, .wr_bank,
        .busy, .bank, .word_count
    );

    obj_table_buf u_buf (
        .clk, .wr_en, .wr_bank, .wr_addr, .wr_data,
        .bank, .table_addr, .table_data
    );

endmodule

/* tb/tb_obj_table.sv */
/*
 * object table dma testbench
 * axi register access, full and terminated copies, double buffering,
 * bus protocol checks and enable or retrigger handling
 */
`timescale 1ns/1ps

module tb_obj_table;

    // four dmas including the reset fill, ten cycles per word at most
    localparam int TIMEOUT = 4 * obj_pkg::TABLE_WORDS * 10 + 2000;
    localparam logic [15:0] BASE_A = 16'h0024;
    localparam logic [15:0] BASE_B = 16'h0146;
    localparam int TERM_ENTRY = 100;

    logic clk = 1'b0;
    logic rst;
    logic vblank;
    logic [obj_pkg::REG_AW-1:0] awaddr;
    logic [obj_pkg::REG_AW-1:0] araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp;
    logic [1:0]  rresp;
    logic busreq, busack, vram_cs, vram_ok;
    logic [obj_pkg::VADDR_W-1:0]  vram_addr;
    logic [15:0]                  vram_data;
    logic [obj_pkg::TABLE_AW-1:0] table_addr;
    logic [15:0]                  table_data;
    logic [15:0] ref_mem [0:(1 << obj_pkg::VADDR_W)-1];
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    obj_table_top DUT (.*);
    vram_model u_vram (.*);

    always #20 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic note_fail(input string msg);
        errors++;
        $display("%0t ns: %s", $time, msg);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    // video ram address of table word 0
    function automatic logic [16:0] table_start(input logic [15:0] base);
        return {base[9:1], 8'h00};
    endfunction

    // words before the first entry whose attribute code ends the table
    function automatic int table_len(input logic [16:0] start);
        obj_pkg::obj_attr_t attr;
        for (int e = 0; e < obj_pkg::TABLE_WORDS / obj_pkg::ENTRY_WORDS; e++) begin
            attr.raw = ref_mem[start + 17'(4 * e + 3)];
            if (attr.fields.code == obj_pkg::END_CODE) return 4 * e;
        end
        return obj_pkg::TABLE_WORDS;
    endfunction

    // entry walks 3,2,1,0 then moves to word 3 of the next entry
    function automatic logic [16:0] next_vaddr(input logic [16:0] a);
        if (a[1:0] == 2'b00) return {a[16:2] + 15'd1, 2'b11};
        return a - 17'd1;
    endfunction

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        // every response is OKAY
        check_val("bresp", 32'd0, bresp);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        check_val("rresp", 32'd0, rresp);
        arvalid = 1'b0;
        data    = rdata;
        rready  = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic check_status(input logic exp_busy, input logic exp_bank, input int exp_cnt);
        logic [31:0] s;
        axi_read(obj_pkg::REG_STATUS, s);
        check_val("status.busy", exp_busy, s[0]);
        check_val("status.bank", exp_bank, s[1]);
        check_val("status.word_count", exp_cnt, s[26:16]);
    endtask

    // polls busy, the watchdog ends a hung dma
    task automatic wait_idle;
        logic [31:0] s;
        s = 32'h1;
        while (s[0]) axi_read(obj_pkg::REG_STATUS, s);
    endtask

    task automatic pulse_vblank;
        @(negedge clk);
        vblank = 1'b1;
        @(negedge clk);
        vblank = 1'b0;
    endtask

    // end code into word 3 of one entry, model and reference alike
    task automatic plant_end(input logic [15:0] base, input int entry);
        obj_pkg::obj_attr_t attr;
        logic [16:0] a;
        a = table_start(base) + 17'(4 * entry + 3);
        attr.raw = ref_mem[a];
        attr.fields.code = obj_pkg::END_CODE;
        ref_mem[a] = attr.raw;
        u_vram.mem[a] = attr.raw;
    endtask

    // walks the display bank, data compared one cycle after its address
    task automatic check_table(input logic [15:0] base);
        logic [16:0] start;
        logic [15:0] exp;
        int len;
        start = table_start(base);
        len = table_len(start);
        for (int i = 0; i <= obj_pkg::TABLE_WORDS; i++) begin
            @(negedge clk);
            if (i > 0) begin
                exp = (i - 1 < len) ? ref_mem[start + 17'(i - 1)] : 16'h0000;
                check_val($sformatf("table_data[%0d]", i - 1), exp, table_data);
            end
            table_addr = (obj_pkg::TABLE_AW)'(i);
        end
    endtask

    // bus protocol
    a_cs_needs_ack: assert property (@(posedge clk) disable iff (rst)
        vram_cs |-> busack)
        else note_fail("vram_cs high without busack");
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        ($past(vram_cs && !vram_ok) && vram_cs) |-> $stable(vram_addr))
        else note_fail("vram_addr moved while a read was pending");
    a_first_word: assert property (@(posedge clk) disable iff (rst)
        $rose(vram_cs) |-> (vram_addr[1:0] == 2'b11))
        else note_fail("copy did not start with the attribute word");
    a_word_order: assert property (@(posedge clk) disable iff (rst)
        (vram_cs && $past(vram_cs) && vram_addr != $past(vram_addr))
        |-> (vram_addr == next_vaddr($past(vram_addr))))
        else note_fail("video ram words not read in 3,2,1,0 order");
    a_req_in_busy: assert property (@(posedge clk) disable iff (rst)
        $fell(busreq) |-> DUT.busy)
        else note_fail("busreq fell after busy");
    a_busy_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(DUT.busy) |-> !busreq)
        else note_fail("busy fell with the bus still requested");
    // one response per accepted axi request
    a_wr_ready_pair: assert property (@(posedge clk) disable iff (rst)
        awready == wready)
        else note_fail("awready and wready not raised together");
    a_wr_resp: assert property (@(posedge clk) disable iff (rst)
        (awvalid && awready) |=> bvalid)
        else note_fail("accepted write got no response");
    a_wr_once: assert property (@(posedge clk) disable iff (rst)
        (bvalid && bready) |=> !bvalid)
        else note_fail("write response repeated");
    a_rd_resp: assert property (@(posedge clk) disable iff (rst)
        (arvalid && arready) |=> rvalid)
        else note_fail("accepted read got no response");
    a_rd_once: assert property (@(posedge clk) disable iff (rst)
        (rvalid && rready) |=> !rvalid)
        else note_fail("read response repeated");

    initial begin
        logic [31:0] rd;
        int len_a;
        int len_b;
        rst        = 1'b1;
        vblank     = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = 32'd0;
        wstrb      = 4'h0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        table_addr = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int a = 0; a < (1 << obj_pkg::VADDR_W); a++) ref_mem[a] = u_vram.mem[a];

        // registers while the reset fill still runs
        check_status(1'b1, 1'b0, 0);
        axi_write(obj_pkg::REG_CTRL, 32'h1);
        axi_read(obj_pkg::REG_CTRL, rd);
        check_val("ctrl", 32'h1, rd);
        axi_write(obj_pkg::REG_BASE, {16'd0, BASE_A});
        axi_read(obj_pkg::REG_BASE, rd);
        check_val("base", {16'd0, BASE_A}, rd);
        axi_read(4'hC, rd);
        check_val("unmapped", 32'd0, rd);
        wait_idle;
        check_status(1'b0, 1'b0, 0);

        // full table, no terminator
        len_a = table_len(table_start(BASE_A));
        pulse_vblank;
        wait_idle;
        check_status(1'b0, 1'b1, len_a);

        // terminated table, second vblank lands while busy
        plant_end(BASE_B, TERM_ENTRY);
        len_b = table_len(table_start(BASE_B));
        axi_write(obj_pkg::REG_BASE, {16'd0, BASE_B});
        pulse_vblank;
        pulse_vblank;
        check_status(1'b1, 1'b0, len_a);
        check_table(BASE_A);
        wait_idle;
        check_status(1'b0, 1'b0, len_b);

        // next flip shows the terminated table
        pulse_vblank;
        check_table(BASE_B);
        wait_idle;
        check_status(1'b0, 1'b1, len_b);

        // disabled, vblank does nothing
        axi_write(obj_pkg::REG_CTRL, 32'h0);
        pulse_vblank;
        repeat (4) @(negedge clk);
        check_val("busreq", 1'b0, busreq);
        check_status(1'b0, 1'b1, len_b);
        check_table(BASE_B);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* tb/vram_model.sv */
/*
 * video ram and bus arbiter model
 * 128k words from an lcg, random grant delay and read latency of 0 to 7 cycles
 */
`timescale 1ns/1ps

module vram_model (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        busreq,
    output logic                        busack,
    input  logic                        vram_cs,
    input  logic [obj_pkg::VADDR_W-1:0] vram_addr,
    output logic [15:0]                 vram_data,
    output logic                        vram_ok
);

    logic [15:0] mem [0:(1 << obj_pkg::VADDR_W)-1];
    logic [31:0] rnd;
    logic [2:0]  grant_cnt;
    logic [2:0]  lat_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        logic [31:0]        s;
        obj_pkg::obj_attr_t w;
        s = 32'h23b9;
        for (int a = 0; a < (1 << obj_pkg::VADDR_W); a++) begin
            s = lcg_next(s);
            w.raw = s[31:16] ^ a[15:0];
            // attribute words never carry the end code unless planted later
            if (a[1:0] == 2'b11 && w.fields.code == obj_pkg::END_CODE)
                w.fields.code = 8'h7F;
            mem[a] = w.raw;
        end
        // delays continue the same sequence
        rnd = s;
    end

    // model outputs change on the falling edge
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            busack    <= 1'b0;
            vram_ok   <= 1'b0;
            vram_data <= 16'h0000;
            grant_cnt <= 3'd0;
            lat_cnt   <= 3'd0;
        end else begin
            // bus taken back as soon as the request drops
            if (!busreq) begin
                busack    <= 1'b0;
                rnd        = lcg_next(rnd);
                grant_cnt <= rnd[18:16];
            end else if (!busack) begin
                if (grant_cnt == 3'd0) busack <= 1'b1;
                else                   grant_cnt <= grant_cnt - 3'd1;
            end
            // one word per address, ok lasts a single cycle
            if (vram_ok) begin
                vram_ok <= 1'b0;
                rnd      = lcg_next(rnd);
                lat_cnt <= rnd[18:16];
            end else if (vram_cs && busack) begin
                if (lat_cnt == 3'd0) begin
                    vram_ok   <= 1'b1;
                    vram_data <= mem[vram_addr];
                end else begin
                    lat_cnt <= lat_cnt - 3'd1;
                end
            end
        end
    end

endmodule
